// File: logic/pma_pkg.sv
package pma_pkg;

  //////////////////////////////////////////////////////////////////////
  // PMA region description
  //////////////////////////////////////////////////////////////////////

  // One attribute region, bounds are word addresses
  // Range is half open: low <= addr < high
  typedef struct packed {
    logic [31:0] word_addr_low;
    logic [31:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        atomic;
  } pma_region_t;

  // Fallback when an address hits no configured region
  // Treated as I/O, so fetch, speculation and AMO all fault
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low:  32'h0000_0000,
    word_addr_high: 32'h0000_0000,
    main:           1'b0,
    bufferable:     1'b0,
    cacheable:      1'b0,
    atomic:         1'b0
  };

  // Used when the region table is empty
  // Whole map behaves as plain main memory
  localparam pma_region_t NO_PMA_R_DEFAULT = '{
    word_addr_low:  32'h0000_0000,
    word_addr_high: 32'h0000_0000,
    main:           1'b1,
    bufferable:     1'b0,
    cacheable:      1'b0,
    atomic:         1'b1
  };

  //////////////////////////////////////////////////////////////////////
  // Request types
  //////////////////////////////////////////////////////////////////////

  // Access kind, fetch means execute, amo means atomic
  typedef enum logic [1:0] {
    OP_LOAD  = 2'b00,
    OP_STORE = 2'b01,
    OP_FETCH = 2'b10,
    OP_AMO   = 2'b11
  } mem_op_e;

  // Incoming request as seen at the upstream port
  typedef struct packed {
    logic [31:0] addr;
    mem_op_e     op;
    logic        speculative;
    logic [31:0] wdata;
  } mem_req_t;

  // Stage 1 result, request plus its word address
  typedef struct packed {
    mem_req_t    req;
    logic [29:0] word_addr;
  } pma_req_t;

  // Checked request sent downstream
  typedef struct packed {
    logic [31:0] addr;
    mem_op_e     op;
    logic [31:0] wdata;
    logic        err;
    logic        bufferable;
    logic        cacheable;
  } mem_out_t;

endpackage

// File: logic/lsu_req_stage.sv
module lsu_req_stage (
  input  logic                clk,
  input  logic                rst_n_i,

  // Upstream request, already credit qualified by the sender
  input  logic                req_valid_i,
  input  pma_pkg::mem_req_t   req_i,

  // Registered request towards the PMA check
  output logic                s1_valid_o,
  output pma_pkg::pma_req_t   s1_req_o
);

  //////////////////////////////////////////////////////////////////////
  // Word address
  //////////////////////////////////////////////////////////////////////

  // Byte offset is dropped here once
  // Later stages compare against region bounds in words
  logic [29:0] word_addr;

  assign word_addr = req_i.addr[31:2];

  //////////////////////////////////////////////////////////////////////
  // Valid register
  //////////////////////////////////////////////////////////////////////

  // No stall anywhere in the pipe
  // Valid simply follows the input one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= req_valid_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload register
  //////////////////////////////////////////////////////////////////////

  // Only load on a valid beat to keep toggling down
  // Contents are ignored whenever s1_valid_o is low
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      s1_req_o.req       <= req_i;
      s1_req_o.word_addr <= word_addr;
    end
  end

endmodule

// File: logic/pma_check_stage.sv
module pma_check_stage #(
  parameter bit                  A_EXTENSION     = 1'b0,
  parameter int unsigned         PMA_NUM_REGIONS = 0,
  parameter pma_pkg::pma_region_t PMA_CFG [(PMA_NUM_REGIONS > 0 ? PMA_NUM_REGIONS-1 : 0):0] =
    '{default: pma_pkg::PMA_R_DEFAULT}
) (
  input  logic                clk,
  input  logic                rst_n_i,

  // From stage 1
  input  logic                s1_valid_i,
  input  pma_pkg::pma_req_t   s1_req_i,

  // Checked request towards the output buffer
  output logic                s2_valid_o,
  output pma_pkg::mem_out_t   s2_out_o
);

  pma_pkg::pma_region_t region;
  logic [31:0]          word_addr;
  logic                 region_atomic;
  logic                 is_fetch;
  logic                 is_amo;
  logic                 err;

  // Region bounds are full 32 bit words, so widen the address
  assign word_addr = {2'b00, s1_req_i.word_addr};

  //////////////////////////////////////////////////////////////////////
  // Region lookup
  //////////////////////////////////////////////////////////////////////

  if (PMA_NUM_REGIONS == 0) begin : g_no_pma
    // Empty table, everything is main memory
    assign region = pma_pkg::NO_PMA_R_DEFAULT;
  end else begin : g_pma
    logic hit;

    // First match in index order wins on overlap
    always_comb begin
      region = pma_pkg::PMA_R_DEFAULT;
      hit    = 1'b0;
      for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
        if (!hit &&
            (word_addr >= PMA_CFG[i].word_addr_low) &&
            (word_addr <  PMA_CFG[i].word_addr_high)) begin
          region = PMA_CFG[i];
          hit    = 1'b1;
        end
      end
    end
  end

  // Without the A extension no region may take an AMO
  if (A_EXTENSION) begin : g_atomic
    assign region_atomic = region.atomic;
  end else begin : g_no_atomic
    assign region_atomic = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Access checks
  //////////////////////////////////////////////////////////////////////

  assign is_fetch = (s1_req_i.req.op == pma_pkg::OP_FETCH);
  assign is_amo   = (s1_req_i.req.op == pma_pkg::OP_AMO);

  // Atomics need an atomic region
  // Speculation and execution only from main memory
  assign err = (is_amo && !region_atomic)                  ||
               (s1_req_i.req.speculative && !region.main) ||
               (is_fetch && !region.main);

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      s2_valid_o <= 1'b0;
    end else begin
      s2_valid_o <= s1_valid_i;
    end
  end

  // Payload carries the byte address, not the word address
  always_ff @(posedge clk) begin
    if (s1_valid_i) begin
      s2_out_o.addr       <= s1_req_i.req.addr;
      s2_out_o.op         <= s1_req_i.req.op;
      s2_out_o.wdata      <= s1_req_i.req.wdata;
      s2_out_o.err        <= err;
      s2_out_o.bufferable <= region.bufferable;
      s2_out_o.cacheable  <= region.cacheable;
    end
  end

endmodule

// File: logic/lsu_out_stage.sv
module lsu_out_stage #(
  parameter int unsigned IN_CREDITS  = 4,
  parameter int unsigned OUT_CREDITS = 2
) (
  input  logic                clk,
  input  logic                rst_n_i,

  // From the PMA check
  input  logic                s2_valid_i,
  input  pma_pkg::mem_out_t   s2_out_i,

  // Downstream side
  input  logic                credit_i,
  output logic                out_valid_o,
  output pma_pkg::mem_out_t   out_o,

  // Credit back to the upstream sender
  output logic                credit_o
);

  // Pointer needs at least one bit even for a single entry
  localparam int unsigned PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
  localparam int unsigned CNT_W = $clog2(IN_CREDITS + 1);
  localparam int unsigned CRD_W = $clog2(OUT_CREDITS + 1);

  pma_pkg::mem_out_t buf_mem [IN_CREDITS];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  fill;
  logic [CRD_W-1:0]  dn_credits;
  logic              push;
  logic              pop;

  //////////////////////////////////////////////////////////////////////
  // Buffer control
  //////////////////////////////////////////////////////////////////////

  // Every stage 2 beat is written, upstream credits bound the depth
  assign push = s2_valid_i;
  // Send when something is held and downstream has room
  assign pop  = (fill != '0) && (dn_credits != '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      dn_credits <= CRD_W'(OUT_CREDITS);
      out_valid_o <= 1'b0;
    end else begin
      if (push) begin
        // Wrap by compare, depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Send and returned credit in one cycle cancel out
      case ({pop, credit_i})
        2'b10:   dn_credits <= dn_credits - 1'b1;
        2'b01:   dn_credits <= dn_credits + 1'b1;
        default: dn_credits <= dn_credits;
      endcase
      out_valid_o <= pop;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage and output data
  //////////////////////////////////////////////////////////////////////

  // Entry written this cycle is readable from the next one on
  always_ff @(posedge clk) begin
    if (push) begin
      buf_mem[wr_ptr] <= s2_out_i;
    end
    if (pop) begin
      out_o <= buf_mem[rd_ptr];
    end
  end

  // An entry leaving frees one upstream slot
  assign credit_o = out_valid_o;

endmodule

// File: logic/lsu_pma_top.sv
module lsu_pma_top #(
  parameter bit                   A_EXTENSION     = 1'b0,
  parameter int unsigned          PMA_NUM_REGIONS = 0,
  parameter pma_pkg::pma_region_t PMA_CFG [(PMA_NUM_REGIONS > 0 ? PMA_NUM_REGIONS-1 : 0):0] =
    '{default: pma_pkg::PMA_R_DEFAULT},
  parameter int unsigned          IN_CREDITS      = 4,
  parameter int unsigned          OUT_CREDITS     = 2
) (
  input  logic                clk,
  input  logic                rst_n_i,

  // Upstream request port, credit based
  input  logic                req_valid_i,
  input  pma_pkg::mem_req_t   req_i,
  output logic                credit_o,

  // Downstream port, credit based
  output logic                out_valid_o,
  output pma_pkg::mem_out_t   out_o,
  input  logic                credit_i
);

  //////////////////////////////////////////////////////////////////////
  // Stage links
  //////////////////////////////////////////////////////////////////////

  logic              s1_valid;
  pma_pkg::pma_req_t s1_req;
  logic              s2_valid;
  pma_pkg::mem_out_t s2_out;

  // Stage 1, register request and form word address
  lsu_req_stage u_req_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .s1_valid_o  (s1_valid),
    .s1_req_o    (s1_req)
  );

  // Stage 2, region lookup and checks
  pma_check_stage #(
    .A_EXTENSION     (A_EXTENSION),
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) u_pma_check (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .s1_valid_i (s1_valid),
    .s1_req_i   (s1_req),
    .s2_valid_o (s2_valid),
    .s2_out_o   (s2_out)
  );

  // Stage 3, buffer sized to the upstream credit pool
  lsu_out_stage #(
    .IN_CREDITS  (IN_CREDITS),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_out_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .s2_valid_i  (s2_valid),
    .s2_out_i    (s2_out),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .credit_o    (credit_o)
  );

endmodule

// File: tests/tb_lsu_pma_ref.svh
`ifndef TB_LSU_PMA_REF_SVH
`define TB_LSU_PMA_REF_SVH

//////////////////////////////////////////////////////////////////////
// Region table, bounds in words, half open
//////////////////////////////////////////////////////////////////////

localparam bit          TB_A_EXT       = 1'b1;
localparam int unsigned TB_NUM_REGIONS = 4;

// 0 main, 1 I/O, 2 main without atomics
// 3 overlaps the top half of region 0 and loses to it there
localparam pma_pkg::pma_region_t TB_REGIONS [TB_NUM_REGIONS-1:0] = '{
  0: '{word_addr_low: 32'h0000_0000, word_addr_high: 32'h0000_4000,
       main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b1},
  1: '{word_addr_low: 32'h0400_0000, word_addr_high: 32'h0400_1000,
       main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
  2: '{word_addr_low: 32'h0800_0000, word_addr_high: 32'h0800_4000,
       main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b0},
  3: '{word_addr_low: 32'h0000_2000, word_addr_high: 32'h0000_6000,
       main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0}
};

//////////////////////////////////////////////////////////////////////
// Random bits
//////////////////////////////////////////////////////////////////////

// Galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One step per bit, bits collected MSB first
task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
  v = '0;
  for (int i = 0; i < n; i++) begin
    st = lfsr_next(st);
    v  = {v[30:0], st[0]};
  end
endtask

//////////////////////////////////////////////////////////////////////
// Expected checked request
//////////////////////////////////////////////////////////////////////

function automatic pma_pkg::mem_out_t ref_check(input pma_pkg::mem_req_t r);
  pma_pkg::mem_out_t o;
  logic [31:0]       wa;
  logic              hit;
  logic              is_main;
  logic              bufb;
  logic              cach;
  logic              atom;
  wa = {2'b00, r.addr[31:2]};
  // No match means I/O with no attributes at all
  hit = 1'b0;
  is_main = 1'b0;
  bufb = 1'b0;
  cach = 1'b0;
  atom = 1'b0;
  for (int i = 0; i < TB_NUM_REGIONS; i++) begin
    if (!hit && wa >= TB_REGIONS[i].word_addr_low && wa < TB_REGIONS[i].word_addr_high) begin
      hit     = 1'b1;
      is_main = TB_REGIONS[i].main;
      bufb    = TB_REGIONS[i].bufferable;
      cach    = TB_REGIONS[i].cacheable;
      atom    = TB_REGIONS[i].atomic;
    end
  end
  o.addr       = r.addr;
  o.op         = r.op;
  o.wdata      = r.wdata;
  o.err        = (r.op == pma_pkg::OP_AMO && !(TB_A_EXT && atom)) ||
                 (r.speculative && !is_main) ||
                 (r.op == pma_pkg::OP_FETCH && !is_main);
  o.bufferable = bufb;
  o.cacheable  = cach;
  return o;
endfunction

`endif

// File: tests/tb_lsu_pma.sv
module tb_lsu_pma;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IN_CREDITS  = 4;
  localparam int unsigned OUT_CREDITS = 2;
  localparam int          TIMEOUT     = 2000;

  `include "tb_lsu_pma_ref.svh"

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req_valid;
  pma_pkg::mem_req_t req;
  logic              up_credit;
  logic              out_valid;
  pma_pkg::mem_out_t out_val;
  logic              dn_credit;

  // Scoreboard and bookkeeping
  pma_pkg::mem_out_t exp_q [$];
  string             test_name = "reset";
  int                errors = 0;
  int                test_err_base = 0;
  int                n_tests = 0;
  int                n_failed = 0;
  int                checks = 0;
  int                sent = 0;
  int                credits_back = 0;
  int                outputs_seen = 0;
  int                sink_owed = 0;
  logic              sink_hold = 1'b0;
  logic [31:0]       stim_lfsr = 32'd77;
  logic [31:0]       sink_lfsr = 32'd77;

  always #10 clk = ~clk;

  lsu_pma_top #(
    .A_EXTENSION     (TB_A_EXT),
    .PMA_NUM_REGIONS (TB_NUM_REGIONS),
    .PMA_CFG         (TB_REGIONS),
    .IN_CREDITS      (IN_CREDITS),
    .OUT_CREDITS     (OUT_CREDITS)
  ) dut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .credit_o    (up_credit),
    .out_valid_o (out_valid),
    .out_o       (out_val),
    .credit_i    (dn_credit)
  );

  //////////////////////////////////////////////////////////////////////
  // Comparison sampled mid cycle where outputs are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare
    pma_pkg::mem_out_t exp_val;
    if (rst_n) begin
      assert (up_credit == out_valid) else begin
        $display("Upstream credit not aligned with output in test %s", test_name);
        errors++;
      end
      if (up_credit) credits_back++;
      if (out_valid) begin
        outputs_seen++;
        sink_owed++;
        assert (exp_q.size() != 0) else begin
          $display("Output appeared with no request pending in test %s", test_name);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_val = exp_q.pop_front();
          checks++;
          assert (out_val == exp_val) else begin
            $display("** Error %s: expected %h, actual %h", test_name, exp_val, out_val);
            errors++;
          end
        end
      end
    end
  end

  // Sink gives credits back one at a time after a random gap
  initial begin : sink
    logic [31:0] d;
    logic [2:0]  delay;
    dn_credit = 1'b0;
    delay = 3'd0;
    forever begin
      @(posedge clk);
      #1;
      dn_credit = 1'b0;
      if (delay != 3'd0) begin
        delay = delay - 3'd1;
      end else if (sink_owed > 0 && !sink_hold) begin
        dn_credit = 1'b1;
        sink_owed--;
        take_bits(sink_lfsr, 3, d);
        delay = d[2:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err_base = errors;
  endtask

  task automatic finish_test();
    n_tests++;
    if (errors != test_err_base) n_failed++;
    $display("Test %s %s, %0d errors", test_name,
             (errors == test_err_base) ? "ok" : "failed", errors - test_err_base);
  endtask

  function automatic pma_pkg::mem_req_t mk_req(input logic [31:0] a, input pma_pkg::mem_op_e op,
                                               input logic spec, input logic [31:0] wd);
    pma_pkg::mem_req_t r;
    r.addr = a;
    r.op = op;
    r.speculative = spec;
    r.wdata = wd;
    return r;
  endfunction

  // Spends one upstream credit, waits for one if none is left
  task automatic send_req(input pma_pkg::mem_req_t r);
    int waited;
    waited = 0;
    while (sent - credits_back >= IN_CREDITS && waited < TIMEOUT) begin
      step();
      waited++;
    end
    assert (waited < TIMEOUT) else begin
      $display("Timeout waiting for an upstream credit in test %s", test_name);
      errors++;
    end
    if (waited < TIMEOUT) begin
      req_valid = 1'b1;
      req = r;
      exp_q.push_back(ref_check(r));
      sent++;
      step();
      req_valid = 1'b0;
    end
  endtask

  // Region picked first, then a 17 bit offset so some land past the end
  task automatic rand_req(output pma_pkg::mem_req_t r);
    logic [31:0] sel;
    logic [31:0] off;
    logic [31:0] opb;
    logic [31:0] spec;
    logic [31:0] wd;
    logic [31:0] base;
    take_bits(stim_lfsr, 2, sel);
    take_bits(stim_lfsr, 17, off);
    take_bits(stim_lfsr, 2, opb);
    take_bits(stim_lfsr, 2, spec);
    take_bits(stim_lfsr, 32, wd);
    case (sel[1:0])
      2'd0:    base = 32'h0000_0000;
      2'd1:    base = 32'h1000_0000;
      2'd2:    base = 32'h2000_0000;
      default: base = 32'h8000_0000;
    endcase
    r = mk_req(base | off, pma_pkg::mem_op_e'(opb[1:0]), spec[1] & spec[0], wd);
  endtask

  // Waits until every request came out and every credit went back
  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || sink_owed != 0) && waited < TIMEOUT) begin
      step();
      waited++;
    end
    assert (waited < TIMEOUT) else begin
      $display("Timeout waiting for outstanding requests in test %s", test_name);
      errors++;
    end
    repeat (3) step();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    pma_pkg::mem_req_t r;
    logic [31:0]       gap;
    int                base_out;
    int                base_crd;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_idle");
    repeat (5) begin
      step();
      assert (!out_valid && !up_credit) else begin
        $display("Output or credit active while idle in test %s", test_name);
        errors++;
      end
    end
    finish_test();

    // One per region, the overlap, and an unmatched address
    start_test("directed");
    send_req(mk_req(32'h0000_0100, pma_pkg::OP_LOAD, 1'b0, 32'h1111_0001));
    send_req(mk_req(32'h1000_0040, pma_pkg::OP_STORE, 1'b0, 32'h2222_0002));
    send_req(mk_req(32'h2000_0080, pma_pkg::OP_LOAD, 1'b0, 32'h3333_0003));
    send_req(mk_req(32'h0000_C000, pma_pkg::OP_FETCH, 1'b0, 32'h4444_0004));
    send_req(mk_req(32'h0001_4000, pma_pkg::OP_LOAD, 1'b0, 32'h5555_0005));
    send_req(mk_req(32'h8000_0000, pma_pkg::OP_STORE, 1'b0, 32'h6666_0006));
    send_req(mk_req(32'h0000_0200, pma_pkg::OP_AMO, 1'b0, 32'h7777_0007));
    drain();
    finish_test();

    start_test("access_errors");
    send_req(mk_req(32'h1000_0000, pma_pkg::OP_FETCH, 1'b0, 32'hDEAD_0001));
    send_req(mk_req(32'h1000_0010, pma_pkg::OP_LOAD, 1'b1, 32'hDEAD_0002));
    send_req(mk_req(32'h2000_0100, pma_pkg::OP_AMO, 1'b0, 32'hDEAD_0003));
    drain();
    finish_test();

    // Sink stalls, buffer fills, sender runs dry
    start_test("back_pressure");
    sink_hold = 1'b1;
    base_out = outputs_seen;
    for (int i = 0; i < IN_CREDITS + OUT_CREDITS; i++) begin
      rand_req(r);
      send_req(r);
    end
    repeat (20) step();
    assert (outputs_seen - base_out <= OUT_CREDITS) else begin
      $display("** Error %s: expected %0d, actual %0d", test_name, OUT_CREDITS,
               outputs_seen - base_out);
      errors++;
    end
    // Sender saturated, only the credits of the sent outputs came back
    assert (sent - credits_back == IN_CREDITS) else begin
      $display("** Error %s: expected %0d, actual %0d", test_name, IN_CREDITS,
               sent - credits_back);
      errors++;
    end
    sink_hold = 1'b0;
    drain();
    assert (outputs_seen - base_out == IN_CREDITS + OUT_CREDITS) else begin
      $display("** Error %s: expected %0d, actual %0d", test_name, IN_CREDITS + OUT_CREDITS,
               outputs_seen - base_out);
      errors++;
    end
    finish_test();

    start_test("random_stream");
    base_out = outputs_seen;
    base_crd = credits_back;
    repeat (300) begin
      rand_req(r);
      send_req(r);
      take_bits(stim_lfsr, 1, gap);
      if (gap[0]) step();
    end
    drain();
    assert (credits_back - base_crd == 300) else begin
      $display("** Error %s: expected %0d, actual %0d", test_name, 300, credits_back - base_crd);
      errors++;
    end
    assert (outputs_seen - base_out == 300) else begin
      $display("** Error %s: expected %0d, actual %0d", test_name, 300, outputs_seen - base_out);
      errors++;
    end
    finish_test();

    $display("%0d tests, %0d failed, %0d outputs compared, %0d errors",
             n_tests, n_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+tests
logic/pma_pkg.sv
logic/lsu_req_stage.sv
logic/pma_check_stage.sv
logic/lsu_out_stage.sv
logic/lsu_pma_top.sv
tests/tb_lsu_pma.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LSU PMA testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

# Compile the package, the RTL and the testbench into one binary
if ! verilator --binary -j 0 --top-module tb_lsu_pma -f verilog.f --Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

# Run it and keep the output for the pass search
if ! sim_out="$(./obj_dir/Vtb_lsu_pma 2>&1)"; then
  echo "$sim_out"
  echo "Simulation exited with a nonzero status"
  exit 1
fi

echo "$sim_out"

# The run only counts when the testbench printed its pass line
if grep -q "^TESTS PASSED$" <<< "$sim_out"; then
  exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
